//--- rtl/dbg_pkg.sv
package dbg_pkg;

    localparam int BYTE_W      = 8;                      // uart byte
    localparam int WORD_W      = 32;                     // instruction and data word
    localparam int INSTR_BYTES = 4;                      // bytes per instruction word
    localparam int ADDR_STEP   = 4;                      // byte address step per word
    localparam int BYTE_CNT_W  = $clog2(INSTR_BYTES);

    localparam logic [BYTE_CNT_W-1:0] LAST_BYTE  = BYTE_CNT_W'(INSTR_BYTES - 1);
    localparam logic [WORD_W-1:0]     HALT_INSTR = 32'hffff_ffff;  // end of program marker

    // one-hot command bytes from the host
    typedef enum logic [BYTE_W-1:0] {
        cmd_load  = 8'h01,
        cmd_debug = 8'h02,
        cmd_run   = 8'h04,
        cmd_step  = 8'h08,
        cmd_end   = 8'h10
    } cmd_t;

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_debug,
        st_run,
        st_dump
    } ctrl_state_t;

    typedef enum logic [1:0] {
        dmp_idle,
        dmp_send,
        dmp_wait,
        dmp_ack
    } dump_state_t;

endpackage

//--- rtl/snap_pkg.sv
package snap_pkg;

    localparam int MEM_ADDR_W = 8;                       // memory address field
    localparam int CTRL_W     = 16;                      // packed control word

    // field positions inside the snapshot with the control word at the bottom
    localparam int CTRL_LSB     = 0;
    localparam int MEM_ADDR_LSB = CTRL_LSB + CTRL_W;
    localparam int MEM_DATA_LSB = MEM_ADDR_LSB + MEM_ADDR_W;
    localparam int ALU_LSB      = MEM_DATA_LSB + dbg_pkg::WORD_W;
    localparam int REG_B_LSB    = ALU_LSB + dbg_pkg::WORD_W;
    localparam int REG_A_LSB    = REG_B_LSB + dbg_pkg::WORD_W;

    localparam int SNAP_W      = REG_A_LSB + dbg_pkg::WORD_W;  // 152 bits
    localparam int SNAP_BYTES  = SNAP_W / dbg_pkg::BYTE_W;     // 19 bytes per dump
    localparam int SNAP_CNT_W  = $clog2(SNAP_BYTES);

    typedef logic [SNAP_CNT_W-1:0] snap_cnt_t;

    localparam snap_cnt_t LAST_SNAP_BYTE = snap_cnt_t'(SNAP_BYTES - 1);

endpackage

//--- rtl/instr_loader.sv
`timescale 1ns/1ps

module instr_loader (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic                       i_load_en,
    input  logic                       i_rx_done,
    input  logic [dbg_pkg::BYTE_W-1:0] i_rx_data,
    output logic [dbg_pkg::WORD_W-1:0] o_instr,
    output logic [dbg_pkg::WORD_W-1:0] o_instr_addr,
    output logic                       o_valid,
    output logic                       o_load_done
);

    logic [dbg_pkg::WORD_W-dbg_pkg::BYTE_W-1:0] shift_q;    // upper bytes so far
    logic [dbg_pkg::BYTE_CNT_W-1:0]             byte_cnt;
    logic [dbg_pkg::WORD_W-1:0]                 next_addr;  // address of word in progress
    logic [dbg_pkg::WORD_W-1:0]                 word_in;
    logic                                       word_done;
    logic                                       is_halt;

    assign word_in   = {shift_q, i_rx_data};                // msb first
    assign word_done = i_load_en && i_rx_done && (byte_cnt == dbg_pkg::LAST_BYTE);
    assign is_halt   = (word_in == dbg_pkg::HALT_INSTR);

    // word payload
    always_ff @(posedge clk) begin
        if (i_load_en && i_rx_done) begin
            shift_q <= word_in[dbg_pkg::WORD_W-dbg_pkg::BYTE_W-1:0];
        end
        if (word_done) begin
            o_instr <= word_in;                             // held until next word
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            byte_cnt     <= '0;
            next_addr    <= '0;
            o_instr_addr <= '0;
            o_valid      <= 1'b0;
            o_load_done  <= 1'b0;
        end else begin
            o_valid     <= word_done;
            o_load_done <= word_done && is_halt;            // same cycle as last o_valid
            if (!i_load_en) begin
                byte_cnt  <= '0;
                next_addr <= '0;
            end else if (i_rx_done) begin
                if (word_done) begin
                    byte_cnt     <= '0;
                    o_instr_addr <= next_addr;
                    if (!is_halt) begin
                        next_addr <= next_addr + dbg_pkg::ADDR_STEP;
                    end
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- rtl/snapshot_dumper.sv
`timescale 1ns/1ps

module snapshot_dumper (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic                            i_dump_req,
    output logic                            o_dump_ack,
    input  logic [dbg_pkg::WORD_W-1:0]      i_reg_a,
    input  logic [dbg_pkg::WORD_W-1:0]      i_reg_b,
    input  logic [dbg_pkg::WORD_W-1:0]      i_alu_result,
    input  logic [dbg_pkg::WORD_W-1:0]      i_mem_data,
    input  logic [snap_pkg::MEM_ADDR_W-1:0] i_mem_addr,
    input  logic [snap_pkg::CTRL_W-1:0]     i_ctrl_word,
    input  logic                            i_tx_done,
    output logic                            o_tx_start,
    output logic [dbg_pkg::BYTE_W-1:0]      o_tx_data
);

    dbg_pkg::dump_state_t        state;
    snap_pkg::snap_cnt_t         idx;       // byte being sent
    logic [snap_pkg::SNAP_W-1:0] snap_in;
    logic [snap_pkg::SNAP_W-1:0] snap_q;    // frozen copy for the whole dump

    // pack the pipeline fields with reg a on top
    always_comb begin
        snap_in[snap_pkg::REG_A_LSB    +: dbg_pkg::WORD_W]     = i_reg_a;
        snap_in[snap_pkg::REG_B_LSB    +: dbg_pkg::WORD_W]     = i_reg_b;
        snap_in[snap_pkg::ALU_LSB      +: dbg_pkg::WORD_W]     = i_alu_result;
        snap_in[snap_pkg::MEM_DATA_LSB +: dbg_pkg::WORD_W]     = i_mem_data;
        snap_in[snap_pkg::MEM_ADDR_LSB +: snap_pkg::MEM_ADDR_W] = i_mem_addr;
        snap_in[snap_pkg::CTRL_LSB     +: snap_pkg::CTRL_W]     = i_ctrl_word;
    end

    always_ff @(posedge clk) begin
        if (state == dbg_pkg::dmp_idle && i_dump_req) begin
            snap_q <= snap_in;                              // capture on first req cycle
        end
        if (state == dbg_pkg::dmp_send) begin
            o_tx_data <= snap_q[dbg_pkg::BYTE_W*idx +: dbg_pkg::BYTE_W];  // lsb first
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= dbg_pkg::dmp_idle;
            idx        <= '0;
            o_dump_ack <= 1'b0;
            o_tx_start <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;                             // single cycle pulse
            case (state)
                dbg_pkg::dmp_idle: begin
                    if (i_dump_req) begin
                        idx   <= '0;
                        state <= dbg_pkg::dmp_send;
                    end
                end
                dbg_pkg::dmp_send: begin
                    o_tx_start <= 1'b1;
                    state      <= dbg_pkg::dmp_wait;
                end
                dbg_pkg::dmp_wait: begin
                    // only one byte in flight at a time
                    if (i_tx_done) begin
                        if (idx == snap_pkg::LAST_SNAP_BYTE) begin
                            o_dump_ack <= 1'b1;
                            state      <= dbg_pkg::dmp_ack;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= dbg_pkg::dmp_send;
                        end
                    end
                end
                dbg_pkg::dmp_ack: begin
                    if (!i_dump_req) begin                  // req dropped so close handshake
                        o_dump_ack <= 1'b0;
                        state      <= dbg_pkg::dmp_idle;
                    end
                end
                default: begin
                    state <= dbg_pkg::dmp_idle;
                end
            endcase
        end
    end

endmodule

//--- rtl/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic                       i_rx_done,
    input  logic [dbg_pkg::BYTE_W-1:0] i_rx_data,
    input  logic                       i_end,
    input  logic                       i_load_done,
    output logic                       o_load_en,
    output logic                       o_dump_req,
    input  logic                       i_dump_ack,
    output logic                       o_step,
    output logic                       o_start
);

    dbg_pkg::ctrl_state_t state;
    dbg_pkg::cmd_t        rx_cmd;
    logic                 dbg_ret;          // current dump goes back to debug

    assign rx_cmd    = dbg_pkg::cmd_t'(i_rx_data);
    assign o_load_en = (state == dbg_pkg::st_load);  // loader owns rx bytes here

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= dbg_pkg::st_idle;
            dbg_ret    <= 1'b0;
            o_dump_req <= 1'b0;
            o_step     <= 1'b0;
            o_start    <= 1'b0;
        end else begin
            o_step <= 1'b0;
            case (state)
                dbg_pkg::st_idle: begin
                    if (i_rx_done) begin
                        case (rx_cmd)
                            dbg_pkg::cmd_load: begin
                                state <= dbg_pkg::st_load;
                            end
                            dbg_pkg::cmd_debug: begin
                                state   <= dbg_pkg::st_debug;
                                o_start <= 1'b1;
                            end
                            dbg_pkg::cmd_run: begin
                                state   <= dbg_pkg::st_run;
                                o_start <= 1'b1;
                            end
                            default: begin
                                state <= dbg_pkg::st_idle;  // unknown byte
                            end
                        endcase
                    end
                end
                dbg_pkg::st_load: begin
                    if (i_load_done) begin
                        state <= dbg_pkg::st_idle;
                    end
                end
                dbg_pkg::st_debug: begin
                    if (i_rx_done) begin
                        case (rx_cmd)
                            dbg_pkg::cmd_step: begin
                                o_step     <= 1'b1;          // step and req together
                                o_dump_req <= 1'b1;
                                dbg_ret    <= 1'b1;
                                state      <= dbg_pkg::st_dump;
                            end
                            dbg_pkg::cmd_end: begin
                                o_dump_req <= 1'b1;          // final dump before idle
                                dbg_ret    <= 1'b0;
                                state      <= dbg_pkg::st_dump;
                            end
                            default: begin
                                state <= dbg_pkg::st_debug;
                            end
                        endcase
                    end
                end
                dbg_pkg::st_run: begin
                    if (i_end) begin
                        o_dump_req <= 1'b1;
                        dbg_ret    <= 1'b0;
                        state      <= dbg_pkg::st_dump;
                    end
                end
                dbg_pkg::st_dump: begin
                    // rx bytes ignored until the dumper is done
                    if (i_dump_ack) begin
                        o_dump_req <= 1'b0;
                        o_start    <= dbg_ret;
                        state      <= dbg_ret ? dbg_pkg::st_debug : dbg_pkg::st_idle;
                    end
                end
                default: begin
                    state <= dbg_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

//--- rtl/debug_uart_ctrl.sv
`timescale 1ns/1ps

module debug_uart_ctrl (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic                            i_rx_done,
    input  logic [dbg_pkg::BYTE_W-1:0]      i_rx_data,
    input  logic                            i_tx_done,
    output logic                            o_tx_start,
    output logic [dbg_pkg::BYTE_W-1:0]      o_tx_data,
    input  logic                            i_end,
    input  logic [dbg_pkg::WORD_W-1:0]      i_reg_a,
    input  logic [dbg_pkg::WORD_W-1:0]      i_reg_b,
    input  logic [dbg_pkg::WORD_W-1:0]      i_alu_result,
    input  logic [dbg_pkg::WORD_W-1:0]      i_mem_data,
    input  logic [snap_pkg::MEM_ADDR_W-1:0] i_mem_addr,
    input  logic [snap_pkg::CTRL_W-1:0]     i_ctrl_word,
    output logic [dbg_pkg::WORD_W-1:0]      o_instr,
    output logic [dbg_pkg::WORD_W-1:0]      o_instr_addr,
    output logic                            o_valid,
    output logic                            o_step,
    output logic                            o_start
);

    logic load_en;      // decoder hands rx bytes to loader
    logic load_done;    // halt word seen
    logic dump_req;
    logic dump_ack;

    cmd_decoder u_cmd_decoder (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_rx_done   (i_rx_done),
        .i_rx_data   (i_rx_data),
        .i_end       (i_end),
        .i_load_done (load_done),
        .o_load_en   (load_en),
        .o_dump_req  (dump_req),
        .i_dump_ack  (dump_ack),
        .o_step      (o_step),
        .o_start     (o_start)
    );

    instr_loader u_instr_loader (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_load_en    (load_en),
        .i_rx_done    (i_rx_done),
        .i_rx_data    (i_rx_data),
        .o_instr      (o_instr),
        .o_instr_addr (o_instr_addr),
        .o_valid      (o_valid),
        .o_load_done  (load_done)
    );

    // sole driver of the uart transmitter
    snapshot_dumper u_snapshot_dumper (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_dump_req   (dump_req),
        .o_dump_ack   (dump_ack),
        .i_reg_a      (i_reg_a),
        .i_reg_b      (i_reg_b),
        .i_alu_result (i_alu_result),
        .i_mem_data   (i_mem_data),
        .i_mem_addr   (i_mem_addr),
        .i_ctrl_word  (i_ctrl_word),
        .i_tx_done    (i_tx_done),
        .o_tx_start   (o_tx_start),
        .o_tx_data    (o_tx_data)
    );

endmodule

//--- bench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic report_failure(input string what);
    $display("error at %0t: %s", $time, what);
    abort_run();
endtask

task automatic check_word(input string name, input logic [dbg_pkg::WORD_W-1:0] got,
                          input logic [dbg_pkg::WORD_W-1:0] exp);
    if (got !== exp) begin
        $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        abort_run();
    end
endtask

task automatic check_byte(input string name, input logic [dbg_pkg::BYTE_W-1:0] got,
                          input logic [dbg_pkg::BYTE_W-1:0] exp);
    if (got !== exp) begin
        $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        abort_run();
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
        abort_run();
    end
endtask

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

`endif

//--- bench/tb_debug_uart_ctrl.sv
`timescale 1ns/1ps

module tb_debug_uart_ctrl;

    localparam int          WAIT_LIMIT = 2000;           // cycles allowed for any one wait
    localparam logic [31:0] SEED       = 32'h3c46_02ec;

    logic                            clk;
    logic                            i_rst_n;
    logic                            i_rx_done;
    logic [dbg_pkg::BYTE_W-1:0]      i_rx_data;
    logic                            i_tx_done;
    logic                            o_tx_start;
    logic [dbg_pkg::BYTE_W-1:0]      o_tx_data;
    logic                            i_end;
    logic [dbg_pkg::WORD_W-1:0]      i_reg_a;
    logic [dbg_pkg::WORD_W-1:0]      i_reg_b;
    logic [dbg_pkg::WORD_W-1:0]      i_alu_result;
    logic [dbg_pkg::WORD_W-1:0]      i_mem_data;
    logic [snap_pkg::MEM_ADDR_W-1:0] i_mem_addr;
    logic [snap_pkg::CTRL_W-1:0]     i_ctrl_word;
    logic [dbg_pkg::WORD_W-1:0]      o_instr;
    logic [dbg_pkg::WORD_W-1:0]      o_instr_addr;
    logic                            o_valid;
    logic                            o_step;
    logic                            o_start;

    logic [dbg_pkg::BYTE_W-1:0] tx_bytes[$];             // every byte the transmitter took
    logic [dbg_pkg::WORD_W-1:0] exp_words[$];
    logic [dbg_pkg::WORD_W-1:0] exp_addrs[$];
    int                         valid_count = 0;
    int                         step_count  = 0;
    logic                       tx_busy     = 1'b0;      // byte in flight
    logic                       hold_start  = 1'b0;      // o_start must stay high
    logic [31:0]                rng         = SEED;

    `include "tb_checks.svh"

    debug_uart_ctrl uut (.*);

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // byte n of the packed snapshot counted from the lsb
    function automatic logic [dbg_pkg::BYTE_W-1:0] ref_snap_byte(
        input logic [dbg_pkg::WORD_W-1:0]      a,
        input logic [dbg_pkg::WORD_W-1:0]      b,
        input logic [dbg_pkg::WORD_W-1:0]      alu,
        input logic [dbg_pkg::WORD_W-1:0]      mdata,
        input logic [snap_pkg::MEM_ADDR_W-1:0] maddr,
        input logic [snap_pkg::CTRL_W-1:0]     ctrl,
        input int                              n
    );
        logic [snap_pkg::SNAP_W-1:0] snap;
        snap = {a, b, alu, mdata, maddr, ctrl};
        return snap[dbg_pkg::BYTE_W*n +: dbg_pkg::BYTE_W];
    endfunction

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // uart transmitter answering each start after 1 to 20 cycles
    initial begin : tx_model
        logic [31:0] tx_rng;
        int          delay;
        tx_rng = SEED;
        i_tx_done <= 1'b0;
        forever begin
            @(negedge clk);
            if (o_tx_start) begin
                tx_busy = 1'b1;
                tx_bytes.push_back(o_tx_data);
                tx_rng = xorshift32(tx_rng);
                delay  = 1 + int'(tx_rng % 32'd20);
                repeat (delay) begin
                    @(negedge clk);
                    check_bit("o_tx_start", o_tx_start, 1'b0);  // byte still outstanding
                end
                @(posedge clk);
                i_tx_done <= 1'b1;
                @(negedge clk);
                check_bit("o_tx_start", o_tx_start, 1'b0);
                @(posedge clk);
                i_tx_done <= 1'b0;
                tx_busy = 1'b0;
            end
        end
    end

    initial begin : output_checker
        forever begin
            @(negedge clk);
            if (o_valid) begin
                if (valid_count >= exp_words.size()) begin
                    report_failure("o_valid pulsed with no word outstanding");
                end else begin
                    check_word("o_instr", o_instr, exp_words[valid_count]);
                    check_word("o_instr_addr", o_instr_addr, exp_addrs[valid_count]);
                    valid_count++;
                end
            end
            if (o_step) begin
                step_count++;
            end
            if (hold_start) begin
                check_bit("o_start", o_start, 1'b1);
            end
        end
    end

    task automatic send_byte(input logic [dbg_pkg::BYTE_W-1:0] b);
        int gap;
        gap = 4 + int'(next_rand() % 32'd8);             // idle line before the byte
        repeat (gap) @(posedge clk);
        i_rx_data <= b;
        i_rx_done <= 1'b1;
        @(posedge clk);
        i_rx_done <= 1'b0;
    endtask

    task automatic wait_words();
        int cyc;
        cyc = 0;
        while (valid_count < exp_words.size()) begin
            @(negedge clk);
            cyc++;
            if (cyc > WAIT_LIMIT) begin
                report_failure("timeout waiting for o_valid");
            end
        end
    endtask

    task automatic load_program(input int n_words);
        logic [dbg_pkg::WORD_W-1:0] w;
        send_byte(dbg_pkg::cmd_load);
        for (int i = 0; i <= n_words; i++) begin
            w = (i == n_words) ? dbg_pkg::HALT_INSTR : next_rand();
            if (i < n_words && w == dbg_pkg::HALT_INSTR) begin
                w = w ^ 32'h1;                           // halt only at the end
            end
            exp_words.push_back(w);
            exp_addrs.push_back(32'(4 * i));
            for (int j = 0; j < 4; j++) begin
                send_byte(w[31:24]);                     // msb first
                w = w << 8;
            end
        end
        wait_words();
    endtask

    task automatic new_snapshot();
        logic [31:0] r;
        @(posedge clk);
        i_reg_a      <= next_rand();
        i_reg_b      <= next_rand();
        i_alu_result <= next_rand();
        i_mem_data   <= next_rand();
        r = next_rand();
        i_mem_addr   <= r[7:0];
        i_ctrl_word  <= r[23:8];
    endtask

    task automatic wait_start(input logic level);
        int cyc;
        cyc = 0;
        while (o_start !== level) begin
            @(negedge clk);
            cyc++;
            if (cyc > WAIT_LIMIT) begin
                report_failure($sformatf("timeout waiting for o_start to become %b", level));
            end
        end
    endtask

    task automatic wait_dump(input int base);
        int cyc;
        cyc = 0;
        while (tx_bytes.size() < base + snap_pkg::SNAP_BYTES || tx_busy) begin
            @(negedge clk);
            cyc++;
            if (cyc > WAIT_LIMIT) begin
                report_failure("timeout waiting for snapshot bytes");
            end
        end
    endtask

    task automatic check_dump(input int base);
        if (tx_bytes.size() != base + snap_pkg::SNAP_BYTES) begin
            report_failure($sformatf("dump gave %0d bytes instead of %0d",
                                     tx_bytes.size() - base, snap_pkg::SNAP_BYTES));
        end else begin
            for (int i = 0; i < snap_pkg::SNAP_BYTES; i++) begin
                check_byte($sformatf("o_tx_data[%0d]", i), tx_bytes[base + i],
                           ref_snap_byte(i_reg_a, i_reg_b, i_alu_result, i_mem_data,
                                         i_mem_addr, i_ctrl_word, i));
            end
        end
    endtask

    initial begin : stimulus
        int base;
        base = 0;
        i_rst_n      <= 1'b0;
        i_rx_done    <= 1'b0;
        i_rx_data    <= '0;
        i_end        <= 1'b0;
        i_reg_a      <= '0;
        i_reg_b      <= '0;
        i_alu_result <= '0;
        i_mem_data   <= '0;
        i_mem_addr   <= '0;
        i_ctrl_word  <= '0;
        repeat (10) @(posedge clk);
        i_rst_n <= 1'b1;
        @(negedge clk);
        check_bit("o_valid", o_valid, 1'b0);
        check_bit("o_step", o_step, 1'b0);
        check_bit("o_start", o_start, 1'b0);
        check_bit("o_tx_start", o_tx_start, 1'b0);

        load_program(8);

        send_byte(dbg_pkg::cmd_run);
        wait_start(1'b1);
        new_snapshot();
        @(posedge clk);
        i_end <= 1'b1;                                   // program finished
        @(posedge clk);
        i_end <= 1'b0;
        wait_dump(base);
        wait_start(1'b0);
        check_dump(base);
        base += snap_pkg::SNAP_BYTES;

        send_byte(dbg_pkg::cmd_debug);
        wait_start(1'b1);
        hold_start = 1'b1;
        for (int k = 1; k <= 3; k++) begin
            new_snapshot();
            send_byte(dbg_pkg::cmd_step);
            wait_dump(base);
            check_dump(base);
            base += snap_pkg::SNAP_BYTES;
            if (step_count != k) begin
                report_failure($sformatf("saw %0d o_step pulses after %0d steps", step_count, k));
            end
        end
        new_snapshot();
        send_byte(dbg_pkg::cmd_end);
        wait_dump(base);
        hold_start = 1'b0;
        wait_start(1'b0);
        check_dump(base);
        base += snap_pkg::SNAP_BYTES;

        send_byte(8'h55);                                // not a command
        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            check_bit("o_start", o_start, 1'b0);
            check_bit("o_tx_start", o_tx_start, 1'b0);
        end
        load_program(2);                                 // addresses restart at 0

        if (tx_bytes.size() != base) begin
            report_failure("transmitter got bytes outside a dump");
        end else if (step_count != 3) begin
            report_failure("o_step pulsed outside debug mode");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- compile.f
+incdir+bench
rtl/dbg_pkg.sv
rtl/snap_pkg.sv
rtl/instr_loader.sv
rtl/snapshot_dumper.sv
rtl/cmd_decoder.sv
rtl/debug_uart_ctrl.sv
bench/tb_debug_uart_ctrl.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f compile.f --top-module tb_debug_uart_ctrl -o tb_sim &&
./obj_dir/tb_sim ||
exit 1
